// ==== demux_params.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tagged demux buffer parameters
// channel count, widths, depth and bypass mask
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DEMUX_PARAMS_SVH
`define DEMUX_PARAMS_SVH

`define DEMUX_NUM_CHAN 4
`define DEMUX_DATA_W 16
// words of storage per buffered channel
`define DEMUX_ELS 4
// channels set here come out without a FIFO
`define DEMUX_UNBUF_MASK 4'b1000
`define DEMUX_DROP_W 8
`define DEMUX_TAG_W (($clog2(`DEMUX_NUM_CHAN) > 0) ? $clog2(`DEMUX_NUM_CHAN) : 1)

`endif

// ==== demux_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tagged demux buffer types
// input beat and configuration write words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "demux_params.svh"

package demux_pkg;

   typedef logic [`DEMUX_TAG_W-1:0] tag_t;

   typedef logic [`DEMUX_DATA_W-1:0] data_t;

   // one word of the multiplexed input stream, tag in the upper bits
   typedef struct packed {
      tag_t  tag;
      data_t data;
   } beat_t;

   // wr loads the enable mask, clr zeroes the drop counter on its own
   typedef struct packed {
      logic                       wr;
      logic [`DEMUX_NUM_CHAN-1:0] en;
      logic                       clr;
   } cfg_wr_t;

endpackage

// ==== tag_router.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tag router
// steers a tagged beat to one channel strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "demux_params.svh"

module tag_router import demux_pkg::*;
(
   input  logic                       clk_i,
   input  logic                       rst_n_i,
   input  logic                       v_i,
   input  tag_t                       tag_i,
   input  logic [`DEMUX_NUM_CHAN-1:0] chan_en_i,
   input  logic [`DEMUX_NUM_CHAN-1:0] ready_i,
   output logic                       yumi_o,
   output logic [`DEMUX_NUM_CHAN-1:0] wr_o,
   output logic                       drop_o
);

   logic [`DEMUX_NUM_CHAN-1:0] hit;
   logic                       en_t;
   logic                       rdy_t;

   // a tag past the channel count hits nothing and looks like a disabled channel
   always_comb
   begin
      en_t  = 1'b0;
      rdy_t = 1'b0;
      for (int c = 0; c < `DEMUX_NUM_CHAN; c++)
      begin
         hit[c]  = (tag_i == tag_t'(c));
         wr_o[c] = v_i & hit[c] & chan_en_i[c] & ready_i[c];
         en_t    = en_t | (hit[c] & chan_en_i[c]);
         rdy_t   = rdy_t | (hit[c] & ready_i[c]);
      end
   end

   // disabled channels always swallow their beat
   assign yumi_o = v_i & (~en_t | rdy_t);
   assign drop_o = yumi_o & ~en_t;

   a_tag_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      yumi_o |-> (int'(tag_i) < `DEMUX_NUM_CHAN));

endmodule

// ==== chan_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// channel FIFO
// one read, one write, valid/ready in and valid/yumi out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "demux_params.svh"

module chan_fifo import demux_pkg::*;
#(
   parameter int els = `DEMUX_ELS
)
(
   input  logic  clk_i,
   input  logic  rst_n_i,
   input  logic  v_i,
   input  data_t data_i,
   output logic  ready_o,
   output logic  v_o,
   output data_t data_o,
   input  logic  yumi_i
);

   localparam int ptr_w = (els > 1) ? $clog2(els) : 1;
   localparam int cnt_w = $clog2(els + 1);

   data_t            mem [els];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;

   // full and empty come straight from the occupancy count
   assign ready_o = (count != cnt_w'(els));
   assign v_o     = (count != '0);
   assign data_o  = mem[rd_ptr];

   always_ff @(posedge clk_i)
   begin
      if (v_i)
      begin
         mem[wr_ptr] <= data_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (v_i)
         begin
            wr_ptr <= (wr_ptr == ptr_w'(els - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (yumi_i)
         begin
            rd_ptr <= (rd_ptr == ptr_w'(els - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // a read and a write in one cycle leave the count unchanged
         case ({v_i, yumi_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // the router upstream must respect ready, the consumer must respect valid
   a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      v_i |-> ready_o);

   a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      yumi_i |-> v_o);

endmodule

// ==== chan_cfg_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// channel configuration registers
// enable mask and saturating drop counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "demux_params.svh"

module chan_cfg_regs import demux_pkg::*;
(
   input  logic                       clk_i,
   input  logic                       rst_n_i,
   input  cfg_wr_t                    cfg_i,
   input  logic                       drop_i,
   output logic [`DEMUX_NUM_CHAN-1:0] chan_en_o,
   output logic [`DEMUX_DROP_W-1:0]   drop_count_o
);

   logic cnt_sat;

   assign cnt_sat = (drop_count_o == '1);

   // all channels come out of reset enabled
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         chan_en_o <= '1;
      end
      else if (cfg_i.wr)
      begin
         chan_en_o <= cfg_i.en;
      end
   end

   // clear wins over a drop seen in the same cycle
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         drop_count_o <= '0;
      end
      else if (cfg_i.clr)
      begin
         drop_count_o <= '0;
      end
      else if (drop_i && !cnt_sat)
      begin
         drop_count_o <= drop_count_o + 1'b1;
      end
   end

   // without a clear the counter only ever moves up, so it never wraps
   a_drop_monotonic: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !cfg_i.clr |=> (drop_count_o >= $past(drop_count_o)));

endmodule

// ==== tagged_demux_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tagged one-to-many demux buffer
// routes each beat into a per-channel FIFO or bypass
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "demux_params.svh"

module tagged_demux_fifo import demux_pkg::*;
#(
   parameter int els = `DEMUX_ELS
)
(
   input  logic                       clk_i,
   input  logic                       rst_n_i,
   input  logic                       v_i,
   input  beat_t                      beat_i,
   output logic                       yumi_o,
   input  logic [`DEMUX_NUM_CHAN-1:0] chan_en_i,
   output logic                       drop_o,
   output logic [`DEMUX_NUM_CHAN-1:0] v_o,
   output data_t [`DEMUX_NUM_CHAN-1:0] data_o,
   input  logic [`DEMUX_NUM_CHAN-1:0] yumi_i
);

   localparam logic [`DEMUX_NUM_CHAN-1:0] unbuf_mask = `DEMUX_UNBUF_MASK;

   logic [`DEMUX_NUM_CHAN-1:0] wr;
   logic [`DEMUX_NUM_CHAN-1:0] ready;

   tag_router tag_router_inst (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .v_i       (v_i),
      .tag_i     (beat_i.tag),
      .chan_en_i (chan_en_i),
      .ready_i   (ready),
      .yumi_o    (yumi_o),
      .wr_o      (wr),
      .drop_o    (drop_o)
   );

   for (genvar i = 0; i < `DEMUX_NUM_CHAN; i++)
   begin : g_chan
      if (unbuf_mask[i])
      begin : g_unbuf
         // bypass channel, the consumer is assumed always ready so yumi_i is ignored
         assign v_o[i]    = wr[i];
         assign data_o[i] = beat_i.data;
         assign ready[i]  = 1'b1;
      end
      else
      begin : g_buf
         chan_fifo #(
            .els (els)
         ) chan_fifo_inst (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .v_i     (wr[i]),
            .data_i  (beat_i.data),
            .ready_o (ready[i]),
            .v_o     (v_o[i]),
            .data_o  (data_o[i]),
            .yumi_i  (yumi_i[i])
         );
      end
   end

endmodule

// ==== demux_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// demux top level
// config registers around the tagged demux buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "demux_params.svh"

module demux_top import demux_pkg::*;
(
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   input  logic                        v_i,
   input  beat_t                       beat_i,
   output logic                        yumi_o,
   output logic [`DEMUX_NUM_CHAN-1:0]  v_o,
   output data_t [`DEMUX_NUM_CHAN-1:0] data_o,
   input  logic [`DEMUX_NUM_CHAN-1:0]  yumi_i,
   input  cfg_wr_t                     cfg_i,
   output logic [`DEMUX_DROP_W-1:0]    drop_count_o
);

   logic [`DEMUX_NUM_CHAN-1:0] chan_en;
   logic                       drop;

   chan_cfg_regs chan_cfg_regs_inst (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .cfg_i        (cfg_i),
      .drop_i       (drop),
      .chan_en_o    (chan_en),
      .drop_count_o (drop_count_o)
   );

   tagged_demux_fifo #(
      .els (`DEMUX_ELS)
   ) tagged_demux_fifo_inst (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .v_i       (v_i),
      .beat_i    (beat_i),
      .yumi_o    (yumi_o),
      .chan_en_i (chan_en),
      .drop_o    (drop),
      .v_o       (v_o),
      .data_o    (data_o),
      .yumi_i    (yumi_i)
   );

endmodule

// ==== tb_demux_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the tagged demux buffer
// table-driven stimulus checked against per-channel queues
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "demux_params.svh"

module tb_demux_top import demux_pkg::*;
();

   localparam int op_beat  = 0;
   localparam int op_block = 1;
   localparam int op_cfg   = 2;
   localparam int op_clr   = 3;
   localparam int op_drain = 4;
   localparam int stall_limit = 8;
   localparam logic [`DEMUX_NUM_CHAN-1:0] buf_mask = ~`DEMUX_UNBUF_MASK;

   // take doubles as the enable mask on config rows
   typedef struct {
      int                         op;
      int                         tag;
      data_t                      data;
      logic [`DEMUX_NUM_CHAN-1:0] take;
      int                         drop;
   } row_t;

   logic                        clk_i;
   logic                        rst_n_i;
   logic                        v_i;
   beat_t                       beat_i;
   logic                        yumi_o;
   logic [`DEMUX_NUM_CHAN-1:0]  v_o;
   data_t [`DEMUX_NUM_CHAN-1:0] data_o;
   logic [`DEMUX_NUM_CHAN-1:0]  yumi_i;
   cfg_wr_t                     cfg_i;
   logic [`DEMUX_DROP_W-1:0]    drop_count_o;

   row_t                       rows[$];
   data_t                      model_q[`DEMUX_NUM_CHAN][$];
   logic [`DEMUX_NUM_CHAN-1:0] en_model;
   integer                     seed = 84;
   int                         checks = 0;
   int                         mismatches = 0;
   int                         failures = 0;
   int                         cycles = 0;
   int                         cycle_limit = 0;

   demux_top demux_top_inst (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .v_i          (v_i),
      .beat_i       (beat_i),
      .yumi_o       (yumi_o),
      .v_o          (v_o),
      .data_o       (data_o),
      .yumi_i       (yumi_i),
      .cfg_i        (cfg_i),
      .drop_count_o (drop_count_o)
   );

   always #20 clk_i = ~clk_i;

   always @(posedge clk_i)
   begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles > cycle_limit)
      begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   task automatic report_mismatch(input string msg);
      mismatches++;
      $display("mismatch at %0t: %s", $time, msg);
   endtask

   task automatic add_row(input int op, input int tag, input data_t data,
                          input logic [`DEMUX_NUM_CHAN-1:0] take, input int drop);
      row_t r;
      r.op   = op;
      r.tag  = tag;
      r.data = data;
      r.take = take;
      r.drop = drop;
      rows.push_back(r);
   endtask

   // buffered valids follow the model queues, bypass valids stay low while idle
   task automatic check_state(input int drop);
      logic exp_v;
      for (int c = 0; c < `DEMUX_NUM_CHAN; c++)
      begin
         exp_v = buf_mask[c] ? (model_q[c].size() != 0) : 1'b0;
         checks++;
         assert (v_o[c] == exp_v)
         else report_mismatch($sformatf("v_o[%0d] is %b, expected %b", c, v_o[c], exp_v));
      end
      checks++;
      assert (drop_count_o == drop)
      else report_mismatch($sformatf("drop count %0d, expected %0d", drop_count_o, drop));
   endtask

   task automatic send_beat(input row_t r);
      int   waited;
      logic accepted;
      waited = 0;
      @(posedge clk_i);
      v_i         <= 1'b1;
      beat_i.tag  <= tag_t'(r.tag);
      beat_i.data <= r.data;
      @(negedge clk_i);
      while (!yumi_o && waited < stall_limit)
      begin
         @(negedge clk_i);
         waited++;
      end
      accepted = yumi_o;
      if (!accepted)
      begin
         failures++;
         $display("stall: beat for channel %0d not accepted after %0d cycles", r.tag, waited);
      end
      else if (waited > 0)
      begin
         failures++;
         $display("beat for channel %0d waited %0d cycles before acceptance", r.tag, waited);
      end
      // a bypass channel shows the word in the cycle it is offered
      if (accepted && !buf_mask[r.tag] && en_model[r.tag])
      begin
         checks++;
         assert (v_o[r.tag] && data_o[r.tag] == r.data)
         else report_mismatch($sformatf("bypass channel %0d shows %b/%h, expected 1/%h",
                                        r.tag, v_o[r.tag], data_o[r.tag], r.data));
      end
      @(posedge clk_i);
      v_i <= 1'b0;
      if (accepted && en_model[r.tag] && buf_mask[r.tag])
      begin
         model_q[r.tag].push_back(r.data);
      end
      @(negedge clk_i);
      check_state(r.drop);
   endtask

   task automatic probe_blocked(input row_t r);
      @(posedge clk_i);
      v_i         <= 1'b1;
      beat_i.tag  <= tag_t'(r.tag);
      beat_i.data <= r.data;
      @(negedge clk_i);
      checks++;
      assert (!yumi_o)
      else report_mismatch($sformatf("yumi_o high for a beat to full channel %0d", r.tag));
      @(posedge clk_i);
      v_i <= 1'b0;
      @(negedge clk_i);
      check_state(r.drop);
   endtask

   task automatic write_cfg(input row_t r);
      @(posedge clk_i);
      cfg_i.wr  <= (r.op == op_cfg);
      cfg_i.en  <= r.take;
      cfg_i.clr <= (r.op == op_clr);
      @(posedge clk_i);
      cfg_i <= '0;
      if (r.op == op_cfg)
      begin
         en_model = r.take;
      end
      @(negedge clk_i);
      check_state(r.drop);
   endtask

   task automatic drain(input row_t r);
      logic [`DEMUX_NUM_CHAN-1:0] takes;
      for (int c = 0; c < `DEMUX_NUM_CHAN; c++)
      begin
         takes[c] = r.take[c] & buf_mask[c] & v_o[c] & (model_q[c].size() != 0);
      end
      @(posedge clk_i);
      yumi_i <= takes;
      @(negedge clk_i);
      for (int c = 0; c < `DEMUX_NUM_CHAN; c++)
      begin
         if (takes[c])
         begin
            checks++;
            assert (data_o[c] == model_q[c][0])
            else report_mismatch($sformatf("channel %0d gives %h, expected %h",
                                           c, data_o[c], model_q[c][0]));
         end
      end
      @(posedge clk_i);
      yumi_i <= '0;
      for (int c = 0; c < `DEMUX_NUM_CHAN; c++)
      begin
         if (takes[c])
         begin
            void'(model_q[c].pop_front());
         end
      end
      @(negedge clk_i);
      check_state(r.drop);
   endtask

   task automatic build_table();
      // one beat per channel straight out of reset
      for (int c = 0; c < `DEMUX_NUM_CHAN; c++)
      begin
         add_row(op_beat, c, data_t'(16'h0a00 + c), '0, 0);
      end
      add_row(op_drain, 0, '0, 4'b0111, 0);
      // mixed traffic on the buffered channels with random takes
      for (int i = 0; i < 12; i++)
      begin
         add_row(op_beat, i % 3, data_t'($random(seed)), '0, 0);
         if (i % 3 == 2)
         begin
            add_row(op_drain, 0, '0, 4'($random(seed)), 0);
         end
      end
      repeat (4) add_row(op_drain, 0, '0, 4'b0111, 0);
      // fill channel 1, then the fifth beat must wait for a take
      for (int i = 0; i < `DEMUX_ELS; i++)
      begin
         add_row(op_beat, 1, data_t'(16'h1100 + i), '0, 0);
      end
      add_row(op_block, 1, 16'h1104, '0, 0);
      add_row(op_drain, 0, '0, 4'b0010, 0);
      add_row(op_beat, 1, 16'h1104, '0, 0);
      repeat (4) add_row(op_drain, 0, '0, 4'b0010, 0);
      add_row(op_beat, 3, 16'h3abc, '0, 0);
      // channel 2 off, its beats are swallowed and counted
      add_row(op_cfg, 0, '0, 4'b1011, 0);
      for (int i = 0; i < 3; i++)
      begin
         add_row(op_beat, 2, data_t'(16'h2200 + i), '0, i + 1);
      end
      add_row(op_beat, 0, 16'h0c00, '0, 3);
      add_row(op_drain, 0, '0, 4'b0001, 3);
      add_row(op_clr, 0, '0, '0, 0);
      add_row(op_cfg, 0, '0, 4'b1111, 0);
      add_row(op_beat, 2, 16'h2300, '0, 0);
      add_row(op_drain, 0, '0, 4'b0100, 0);
   endtask

   initial
   begin
      clk_i    = 1'b0;
      rst_n_i  = 1'b0;
      v_i      = 1'b0;
      beat_i   = '0;
      yumi_i   = '0;
      cfg_i    = '0;
      en_model = '1;
      build_table();
      cycle_limit = rows.size() * 20 + 10;
      repeat (10) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);
      check_state(0);
      foreach (rows[i])
      begin
         case (rows[i].op)
            op_beat:  send_beat(rows[i]);
            op_block: probe_blocked(rows[i]);
            op_drain: drain(rows[i]);
            default:  write_cfg(rows[i]);
         endcase
      end
      for (int c = 0; c < `DEMUX_NUM_CHAN; c++)
      begin
         if (model_q[c].size() != 0)
         begin
            failures++;
            $display("channel %0d still holds %0d words at the end", c, model_q[c].size());
         end
      end
      $display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
      if (mismatches + failures == 0)
      begin
         $display("PASS: all tests");
      end
      else
      begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// ==== flist.f ====
+incdir+.
demux_pkg.sv
tag_router.sv
chan_fifo.sv
chan_cfg_regs.sv
tagged_demux_fifo.sv
demux_top.sv
tb_demux_top.sv

// ==== Bender.yml ====
package:
  name: tagged_demux

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - demux_pkg.sv
      - tag_router.sv
      - chan_fifo.sv
      - chan_cfg_regs.sv
      - tagged_demux_fifo.sv
      - demux_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_demux_top.sv
